//--- source/routerPkg.sv
package routerPkg;

	// router geometry
	localparam int portCount = 5;
	localparam int queueDepth = 4;

	// port bit positions, north in the top bit like the turn codes
	localparam int portNorth = 4;
	localparam int portSouth = 3;
	localparam int portEast = 2;
	localparam int portWest = 1;
	localparam int portLocal = 0;

	typedef logic [3:0] coord_t;

	// one flit, destination first
	typedef struct packed {
		coord_t destX;
		coord_t destY;
		logic [7:0] payload;
	} flit_t;

	// one-hot over the ports, used for turns, wants and selects
	typedef logic [portCount-1:0] portOneHot_t;

	// one flag per port
	typedef logic [portCount-1:0] portFlags_t;

endpackage

//--- source/inputQueue.sv
`timescale 1ns/100ps

module inputQueue (
	input  logic clk_i,
	input  logic arstN_i,
	input  logic valid_i,
	input  routerPkg::flit_t flit_i,
	input  logic remove_i,
	output logic full_o,
	output logic headValid_o,
	output routerPkg::flit_t headFlit_o,
	output logic credit_o
);
	import routerPkg::*;

	flit_t mem [queueDepth];
	logic [$clog2(queueDepth)-1:0] wrPtr;
	logic [$clog2(queueDepth)-1:0] rdPtr;
	logic [$clog2(queueDepth+1)-1:0] count;
	logic push;
	logic pop;

	assign full_o = (count == queueDepth);
	assign headValid_o = (count != '0);
	assign headFlit_o = mem[rdPtr];

	assign push = valid_i && !full_o;
	assign pop = remove_i && headValid_o;

	// storage, no reset needed
	always_ff @(posedge clk_i) begin
		if (push) begin
			mem[wrPtr] <= flit_i;
		end
	end

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == queueDepth - 1) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == queueDepth - 1) ? '0 : rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back upstream per departure
			credit_o <= pop;
		end
	end

endmodule

//--- source/turnArbiter.sv
`timescale 1ns/100ps

module turnArbiter (
	input  logic clk_i,
	input  logic arstN_i,
	input  routerPkg::portOneHot_t [routerPkg::portCount-1:0] want_i,
	input  routerPkg::portFlags_t remove_i,
	output routerPkg::portOneHot_t [routerPkg::portCount-1:0] turn_o
);
	import routerPkg::*;

	logic [$clog2(portCount)-1:0] lastServed [portCount];
	logic [$clog2(portCount)-1:0] grantIdx [portCount];

	// search from the farthest candidate down so the nearest one wins
	always_comb begin
		int idx;
		for (int o = 0; o < portCount; o++) begin
			turn_o[o] = '0;
			grantIdx[o] = lastServed[o];
			for (int k = portCount; k >= 1; k--) begin
				idx = (int'(lastServed[o]) + k) % portCount;
				if (want_i[o][idx]) begin
					turn_o[o] = '0;
					turn_o[o][idx] = 1'b1;
					grantIdx[o] = ($clog2(portCount))'(idx);
				end
			end
		end
	end

	// pointer only moves once the granted flit actually leaves
	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			for (int o = 0; o < portCount; o++) begin
				lastServed[o] <= '0;
			end
		end else begin
			for (int o = 0; o < portCount; o++) begin
				if ((turn_o[o] & remove_i) != '0) begin
					lastServed[o] <= grantIdx[o];
				end
			end
		end
	end

endmodule

//--- source/routeLogic.sv
`timescale 1ns/100ps

module routeLogic #(
	parameter routerPkg::coord_t xCoord = 4'd0,
	parameter routerPkg::coord_t yCoord = 4'd0
) (
	input  routerPkg::portFlags_t headValid_i,
	input  routerPkg::flit_t [routerPkg::portCount-1:0] headFlit_i,
	input  routerPkg::portOneHot_t [routerPkg::portCount-1:0] turn_i,
	input  routerPkg::portFlags_t stageFull_i,
	output routerPkg::portOneHot_t [routerPkg::portCount-1:0] want_o,
	output routerPkg::portFlags_t remove_o,
	output routerPkg::portFlags_t enable_o,
	output routerPkg::portOneHot_t [routerPkg::portCount-1:0] select_o
);
	import routerPkg::*;

	// Y-first: settle the row, then the column, local when both match
	function automatic portOneHot_t routeDir(flit_t f);
		portOneHot_t dir;
		dir = '0;
		if (f.destY > yCoord) begin
			dir[portSouth] = 1'b1;
		end else if (f.destY < yCoord) begin
			dir[portNorth] = 1'b1;
		end else if (f.destX > xCoord) begin
			dir[portEast] = 1'b1;
		end else if (f.destX < xCoord) begin
			dir[portWest] = 1'b1;
		end else begin
			dir[portLocal] = 1'b1;
		end
		return dir;
	endfunction

	// per-input direction turned around into per-output want masks
	always_comb begin
		portOneHot_t dir;
		want_o = '0;
		for (int i = 0; i < portCount; i++) begin
			dir = headValid_i[i] ? routeDir(headFlit_i[i]) : '0;
			for (int o = 0; o < portCount; o++) begin
				want_o[o][i] = dir[o];
			end
		end
	end

	// an output moves a flit when its turn holder still wants it
	// and the output register has room
	always_comb begin
		portOneHot_t granted;
		remove_o = '0;
		enable_o = '0;
		select_o = '0;
		for (int o = 0; o < portCount; o++) begin
			granted = turn_i[o] & want_o[o];
			if ((granted != '0) && !stageFull_i[o]) begin
				enable_o[o] = 1'b1;
				select_o[o] = granted;
				// each head wants a single output, so no input is removed twice
				remove_o = remove_o | granted;
			end
		end
	end

endmodule

//--- source/outputStage.sv
`timescale 1ns/100ps

module outputStage (
	input  logic clk_i,
	input  logic arstN_i,
	input  logic enable_i,
	input  routerPkg::portOneHot_t select_i,
	input  routerPkg::flit_t [routerPkg::portCount-1:0] flits_i,
	input  logic outFull_i,
	output logic stageFull_o,
	output logic outValid_o,
	output routerPkg::flit_t outFlit_o
);
	import routerPkg::*;

	flit_t muxFlit;

	// one-hot crossbar leg
	always_comb begin
		muxFlit = '0;
		for (int i = 0; i < portCount; i++) begin
			if (select_i[i]) begin
				muxFlit = muxFlit | flits_i[i];
			end
		end
	end

	// busy only while downstream refuses the flit
	assign stageFull_o = outValid_o && outFull_i;

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			outValid_o <= 1'b0;
		end else if (enable_i) begin
			outValid_o <= 1'b1;
		end else if (!outFull_i) begin
			outValid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (enable_i) begin
			outFlit_o <= muxFlit;
		end
	end

endmodule

//--- source/meshRouter.sv
`timescale 1ns/100ps

module meshRouter #(
	parameter routerPkg::coord_t xCoord = 4'd0,
	parameter routerPkg::coord_t yCoord = 4'd0
) (
	input  logic clk_i,
	input  logic arstN_i,
	input  routerPkg::portFlags_t inValid_i,
	input  routerPkg::flit_t [routerPkg::portCount-1:0] inFlit_i,
	output routerPkg::portFlags_t inFull_o,
	output routerPkg::portFlags_t creditRet_o,
	output routerPkg::portFlags_t outValid_o,
	output routerPkg::flit_t [routerPkg::portCount-1:0] outFlit_o,
	input  routerPkg::portFlags_t outFull_i
);
	import routerPkg::*;

	portFlags_t headValid;
	flit_t [portCount-1:0] headFlit;
	portOneHot_t [portCount-1:0] want;
	portOneHot_t [portCount-1:0] turn;
	portOneHot_t [portCount-1:0] select;
	portFlags_t stageFull;
	portFlags_t remove;
	portFlags_t enable;

	for (genvar p = 0; p < portCount; p++) begin : gQueue
		inputQueue queueInst (
			.clk_i(clk_i),
			.arstN_i(arstN_i),
			.valid_i(inValid_i[p]),
			.flit_i(inFlit_i[p]),
			.remove_i(remove[p]),
			.full_o(inFull_o[p]),
			.headValid_o(headValid[p]),
			.headFlit_o(headFlit[p]),
			.credit_o(creditRet_o[p])
		);
	end

	turnArbiter arbiterInst (
		.clk_i(clk_i),
		.arstN_i(arstN_i),
		.want_i(want),
		.remove_i(remove),
		.turn_o(turn)
	);

	routeLogic #(
		.xCoord(xCoord),
		.yCoord(yCoord)
	) routeInst (
		.headValid_i(headValid),
		.headFlit_i(headFlit),
		.turn_i(turn),
		.stageFull_i(stageFull),
		.want_o(want),
		.remove_o(remove),
		.enable_o(enable),
		.select_o(select)
	);

	for (genvar p = 0; p < portCount; p++) begin : gStage
		outputStage stageInst (
			.clk_i(clk_i),
			.arstN_i(arstN_i),
			.enable_i(enable[p]),
			.select_i(select[p]),
			.flits_i(headFlit),
			.outFull_i(outFull_i[p]),
			.stageFull_o(stageFull[p]),
			.outValid_o(outValid_o[p]),
			.outFlit_o(outFlit_o[p])
		);
	end

endmodule

//--- tests/routerChecker.sv
`timescale 1ns/100ps

module routerChecker (
	input  logic clk_i,
	input  logic arstN_i,
	input  routerPkg::portFlags_t outValid_i,
	input  routerPkg::flit_t [routerPkg::portCount-1:0] outFlit_i,
	input  routerPkg::portFlags_t outFull_i,
	input  routerPkg::portFlags_t creditRet_i
);
	import routerPkg::*;

	typedef struct packed {
		logic [2:0] inPort;
		logic [2:0] outPort;
		flit_t flit;
	} expect_t;

	// one shared list, names kept alongside
	expect_t expList[$];
	string nameList[$];
	int accepted [portCount] = '{default: 0};
	int credits [portCount] = '{default: 0};
	int valueErrors = 0;
	int orderErrors = 0;
	int otherErrors = 0;

	task automatic addExpected(input string name, input int inPort, input int outPort,
			input flit_t flit);
		expect_t e;
		e.inPort = 3'(inPort);
		e.outPort = 3'(outPort);
		e.flit = flit;
		expList.push_back(e);
		nameList.push_back(name);
		accepted[inPort]++;
	endtask

	task automatic reportError(input string msg);
		$display("ERROR: %s", msg);
		otherErrors++;
	endtask

	function automatic int pendingCount();
		return expList.size();
	endfunction

	function automatic int errorCount();
		return valueErrors + orderErrors + otherErrors;
	endfunction

	task automatic checkDelivery(input int o, input flit_t flit);
		int hit;
		int oldest;
		hit = -1;
		oldest = -1;
		// payloads are unique, so they identify the entry
		for (int k = 0; k < expList.size(); k++) begin
			if (hit < 0 && expList[k].flit.payload == flit.payload) begin
				hit = k;
			end
		end
		if (hit < 0) begin
			$display("ERROR: output %0d delivered unknown payload %h", o, flit.payload);
			otherErrors++;
			return;
		end
		for (int k = 0; k <= hit; k++) begin
			if (oldest < 0 && expList[k].inPort == expList[hit].inPort
					&& expList[k].outPort == expList[hit].outPort) begin
				oldest = k;
			end
		end
		if (int'(expList[hit].outPort) != o) begin
			$display("[FAIL] %s port: expected %0d, actual %0d", nameList[hit],
				expList[hit].outPort, o);
			valueErrors++;
		end
		if (expList[hit].flit != flit) begin
			$display("[FAIL] %s flit: expected %h, actual %h", nameList[hit],
				expList[hit].flit, flit);
			valueErrors++;
		end
		if (oldest != hit) begin
			$display("[FAIL] %s order: expected payload %h, actual %h", nameList[hit],
				expList[oldest].flit.payload, flit.payload);
			orderErrors++;
		end
		expList.delete(hit);
		nameList.delete(hit);
	endtask

	// sampled mid-cycle, the values the next edge will see
	always @(negedge clk_i) begin
		if (arstN_i) begin
			for (int o = 0; o < portCount; o++) begin
				if (outValid_i[o] && !outFull_i[o]) begin
					checkDelivery(o, outFlit_i[o]);
				end
				if (creditRet_i[o]) begin
					credits[o]++;
				end
			end
		end
	end

	task automatic closeReport();
		for (int p = 0; p < portCount; p++) begin
			if (credits[p] != accepted[p]) begin
				$display("[FAIL] credits of port %0d: expected %0d, actual %0d", p,
					accepted[p], credits[p]);
				valueErrors++;
			end
		end
		$display("errors: %0d value, %0d order, %0d other", valueErrors, orderErrors,
			otherErrors);
	endtask

endmodule

//--- tests/meshRouter_assert.sv
`timescale 1ns/100ps

module meshRouter_assert (
	input  logic clk_i,
	input  logic arstN_i,
	input  routerPkg::portOneHot_t [routerPkg::portCount-1:0] want_i,
	input  routerPkg::portOneHot_t [routerPkg::portCount-1:0] turn_i,
	input  routerPkg::portOneHot_t [routerPkg::portCount-1:0] select_i,
	input  routerPkg::portFlags_t outValid_i,
	input  routerPkg::portFlags_t outFull_i,
	input  routerPkg::flit_t [routerPkg::portCount-1:0] outFlit_i
);
	import routerPkg::*;

	localparam portOneHot_t sideInputs =
		(portOneHot_t'(1) << portEast) | (portOneHot_t'(1) << portWest);

	for (genvar o = 0; o < portCount; o++) begin : gOut
		// a turn names one input that wants the output, and exists whenever one does
		turnOneHot: assert property (@(posedge clk_i) disable iff (!arstN_i)
			$onehot0(turn_i[o]) && ((turn_i[o] & ~want_i[o]) == '0)
			&& ((turn_i[o] == '0) == (want_i[o] == '0)))
			else $error("turn of output %0d does not name exactly one wanting input", o);

		// refused flit stays put until taken
		holdStable: assert property (@(posedge clk_i) disable iff (!arstN_i)
			outValid_i[o] && outFull_i[o] |=> outValid_i[o] && $stable(outFlit_i[o]))
			else $error("output %0d changed its flit while held", o);
	end

	// east and west traffic already sits on its row
	noSideToColumn: assert property (@(posedge clk_i) disable iff (!arstN_i)
		((select_i[portNorth] | select_i[portSouth]) & sideInputs) == '0)
		else $error("flit from east or west sent toward north or south");

endmodule

bind meshRouter meshRouter_assert assertInst (
	.clk_i(clk_i),
	.arstN_i(arstN_i),
	.want_i(want),
	.turn_i(turn),
	.select_i(select),
	.outValid_i(outValid_o),
	.outFull_i(outFull_i),
	.outFlit_i(outFlit_o)
);

//--- tests/routerTb.sv
`timescale 1ns/100ps

module routerTb;
	import routerPkg::*;

	localparam int maxRecords = 64;
	localparam int waitLimit = 200;

	logic clk = 1'b0;
	logic arstN;
	portFlags_t inValid;
	flit_t [portCount-1:0] inFlit;
	portFlags_t inFull;
	portFlags_t creditRet;
	portFlags_t outValid;
	flit_t [portCount-1:0] outFlit;
	portFlags_t outFull;

	string recName [maxRecords];
	int recGroup [maxRecords];
	int recMode [maxRecords];
	int recIn [maxRecords];
	int recOut [maxRecords];
	flit_t recFlit [maxRecords];
	int recCount;
	int blockedIn;
	logic blockActive;
	logic reported = 1'b0;

	always #50 clk = ~clk;

	meshRouter #(.xCoord(4'd5), .yCoord(4'd5)) DUT (
		.clk_i(clk),
		.arstN_i(arstN),
		.inValid_i(inValid),
		.inFlit_i(inFlit),
		.inFull_o(inFull),
		.creditRet_o(creditRet),
		.outValid_o(outValid),
		.outFlit_o(outFlit),
		.outFull_i(outFull)
	);

	routerChecker checkInst (
		.clk_i(clk),
		.arstN_i(arstN),
		.outValid_i(outValid),
		.outFlit_i(outFlit),
		.outFull_i(outFull),
		.creditRet_i(creditRet)
	);

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic loadGolden();
		int fd;
		int n;
		int g, m, ip, dx, dy, pl, op;
		string line;
		string name;
		recCount = 0;
		fd = $fopen("tests/routerGolden.txt", "r");
		if (fd == 0) begin
			checkInst.reportError("could not open tests/routerGolden.txt");
			return;
		end
		while (!$feof(fd) && recCount < maxRecords) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %d %d %d %d %d %h %d", name, g, m, ip, dx, dy, pl, op);
				if (n == 8) begin
					recName[recCount] = name;
					recGroup[recCount] = g;
					recMode[recCount] = m;
					recIn[recCount] = ip;
					recOut[recCount] = op;
					recFlit[recCount] = '{destX: coord_t'(dx), destY: coord_t'(dy),
						payload: 8'(pl)};
					recCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	// one record per port, all driven together
	task automatic injectGroup(input int first, input int last);
		portFlags_t pending;
		portFlags_t taken;
		int slot [portCount];
		int guard;
		pending = '0;
		for (int r = first; r <= last; r++) begin
			inValid[recIn[r]] = 1'b1;
			inFlit[recIn[r]] = recFlit[r];
			slot[recIn[r]] = r;
			pending[recIn[r]] = 1'b1;
		end
		guard = 0;
		while (pending != '0 && guard < waitLimit) begin
			taken = pending & ~inFull;
			nextCycle();
			if (recMode[first] == 1) begin
				outFull = portFlags_t'($urandom);
			end
			for (int p = 0; p < portCount; p++) begin
				if (taken[p]) begin
					checkInst.addExpected(recName[slot[p]], p, recOut[slot[p]], recFlit[slot[p]]);
					inValid[p] = 1'b0;
				end
			end
			pending = pending & ~taken;
			guard++;
		end
		if (pending != '0) begin
			checkInst.reportError("timed out waiting for the router to accept a flit");
			inValid = '0;
		end
	endtask

	// keep outputs randomly stalled until every flit in flight has left
	task automatic drainUnderPressure();
		int guard;
		guard = 0;
		while (checkInst.pendingCount() != 0 && guard < waitLimit) begin
			nextCycle();
			outFull = portFlags_t'($urandom);
			guard++;
		end
		outFull = '0;
		if (checkInst.pendingCount() != 0) begin
			checkInst.reportError("timed out delivering flits under random back-pressure");
		end
	endtask

	task automatic releaseBlock();
		int guard;
		guard = 0;
		while (!inFull[blockedIn] && guard < waitLimit) begin
			nextCycle();
			guard++;
		end
		if (!inFull[blockedIn]) begin
			checkInst.reportError("input queue never reported full behind a blocked output");
		end
		outFull = '0;
		blockActive = 1'b0;
	endtask

	initial begin
		int first;
		int last;
		int guard;
		void'($urandom(32'hd60ed074));
		arstN = 1'b0;
		inValid = '0;
		inFlit = '0;
		outFull = '0;
		blockActive = 1'b0;
		blockedIn = 0;
		loadGolden();
		repeat (10) @(posedge clk);
		#1;
		arstN = 1'b1;
		// quiet router before the first flit
		for (int c = 0; c < 3; c++) begin
			nextCycle();
			if (outValid != '0 || creditRet != '0 || inFull != '0) begin
				checkInst.reportError("router outputs active before any injection");
			end
		end
		first = 0;
		while (first < recCount) begin
			last = first;
			while (last + 1 < recCount && recGroup[last + 1] == recGroup[first]) begin
				last++;
			end
			if (blockActive && recMode[first] != 2) begin
				releaseBlock();
			end
			if (recMode[first] == 0) begin
				outFull = '0;
			end else if (recMode[first] == 2 && !blockActive) begin
				outFull = '0;
				outFull[recOut[first]] = 1'b1;
				blockedIn = recIn[first];
				blockActive = 1'b1;
			end
			injectGroup(first, last);
			if (recMode[first] == 1) begin
				drainUnderPressure();
			end
			first = last + 1;
		end
		if (blockActive) begin
			releaseBlock();
		end
		outFull = '0;
		guard = 0;
		while (checkInst.pendingCount() != 0 && guard < waitLimit) begin
			nextCycle();
			guard++;
		end
		if (checkInst.pendingCount() != 0) begin
			checkInst.reportError("timed out waiting for every flit to be delivered");
		end
		nextCycle();
		checkInst.closeReport();
		reported = 1'b1;
		if (checkInst.errorCount() == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// run stopped early by a failing assertion
	final begin
		if (!reported) begin
			$display("=== FAIL ===");
		end
	end

endmodule

//--- all.f
source/routerPkg.sv
source/inputQueue.sv
source/turnArbiter.sv
source/routeLogic.sv
source/outputStage.sv
source/meshRouter.sv
tests/routerChecker.sv
tests/meshRouter_assert.sv
tests/routerTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module routerTb -f all.f -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q -x "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/routerGolden.txt
# name group mode inPort destX destY payload(hex) expPort
# ports 4 north 3 south 2 east 1 west 0 local; mode 0 plain, 1 random back-pressure, 2 blocked
rtSouthX  1 0 4 7 8 01 3
rtNorth   1 0 3 5 2 02 4
rtWest    1 0 2 2 5 03 1
rtEast    1 0 1 9 5 04 2
rtLocalIn 1 0 0 3 9 05 3
lcNorth   2 0 4 5 5 06 0
lcWest    2 0 1 5 5 07 0
ctNorth   3 0 4 2 5 20 1
ctSouth   3 0 3 2 5 21 1
ctEast    3 0 2 2 5 22 1
ctLocal   3 0 0 2 5 23 1
ctWest    3 0 1 5 5 24 0
bpNorth   4 1 4 3 7 30 3
bpSouth   4 1 3 6 1 31 4
bpEast    4 1 2 5 5 32 0
bpWest    4 1 1 8 5 33 2
bpLocal   4 1 0 5 3 34 4
blk0      5 2 1 9 5 40 2
blk1      6 2 1 9 5 41 2
blk2      7 2 1 9 5 42 2
blk3      8 2 1 9 5 43 2
blk4      9 2 1 9 5 44 2
